//--- verilog/audioSettings.svh
// Build-time settings of the I2S audio player
// Widths, buffer sizing, memory base address and frame geometry
`ifndef AUDIO_SETTINGS_SVH
`define AUDIO_SETTINGS_SVH

//////////////////////////////////////////////////
// Sample and memory widths
//////////////////////////////////////////////////
`define AUDIO_SAMPLE_W 16          // Bits per audio sample
`define AUDIO_ADDR_W 25            // Word address width of the external memory

//////////////////////////////////////////////////
// Sample buffer
//////////////////////////////////////////////////
// Depth must stay a power of two so the pointers wrap on their own
`define AUDIO_FIFO_DEPTH 64
`define AUDIO_LEVEL_W 7            // Holds 0 up to the full depth
`define AUDIO_FILL_TARGET 48       // Occupancy reached by a prime or a refill

// First word of the sample stream in external memory
`define AUDIO_BASE_ADDR 25'h80000

//////////////////////////////////////////////////
// I2S frame geometry
//////////////////////////////////////////////////
`define AUDIO_SLOTS 32             // Bit slots in one left or right half frame
`define AUDIO_SLOT_W 5             // Width of the slot index

`endif

//--- verilog/audioPkg.sv
// Shared types of the I2S audio player
// Vector widths with a meaning, FSM states and the bundled strobes
`include "audioSettings.svh"

package audioPkg;

	//////////////////////////////////////////////////
	// Plain vector types
	//////////////////////////////////////////////////
	typedef logic [`AUDIO_SAMPLE_W-1:0] sampleT;     // One PCM sample
	typedef logic [`AUDIO_ADDR_W-1:0]   memAddrT;    // External memory word address
	typedef logic [`AUDIO_LEVEL_W-1:0]  fifoLevelT;  // Buffer occupancy in samples
	typedef logic [`AUDIO_SLOT_W-1:0]   slotT;       // Bit slot inside a half frame

	// States of the fetch engine
	typedef enum logic [2:0]
	{
		Halted,      // Waiting for memory after reset
		Request,     // Setting up the next read
		Await,       // Read strobe held until the memory acknowledges
		Play,        // Buffer primed and playback running
		RefillWait   // Frame pulse seen, memory still busy
	} fetchStateT;

	//////////////////////////////////////////////////
	// Bundled signals
	//////////////////////////////////////////////////
	// Read request toward the external memory
	typedef struct packed
	{
		logic    rd;    // Held high until memAck
		memAddrT addr;  // Stable for the whole read
	} memReqT;

	// Frame timing handed from the timer to the serializer
	typedef struct packed
	{
		logic lrClk;          // Channel select, low for the left half
		slotT slot;           // Current bit slot
		logic sampleRequest;  // Load the next sample, last slot only
	} frameTickT;

endpackage

//--- verilog/sampleFetchFsm.sv
// Sample fetch engine of the I2S player
// Primes the buffer once memory is ready and tops it up on each frame pulse
`include "audioSettings.svh"

module sampleFetchFsm import audioPkg::*;
(
	input  logic      SClk,
	input  logic      reset,
	input  logic      memWait,
	input  logic      memAck,
	input  logic      newFrame,
	input  fifoLevelT level,
	output memReqT    memReq,
	output logic      push,
	output logic      busy,
	output logic      playing
);

	localparam fifoLevelT fillTarget = fifoLevelT'(`AUDIO_FILL_TARGET);
	localparam memAddrT   baseAddr   = `AUDIO_BASE_ADDR;

	fetchStateT state, nextState;
	fifoLevelT  remaining;  // Words still to read in the current fill
	memAddrT    nextAddr;   // Address of the next word, runs on across all fills
	logic       rdReg;      // Read strobe toward memory
	memAddrT    addrReg;    // Address latched for the read in flight

	//////////////////////////////////////////////////
	// Next state
	//////////////////////////////////////////////////
	always_comb
	begin
		nextState = state;
		case (state)
			Halted:
				if (!memWait)
					nextState = Request;  // Priming starts right away
			Request:
				nextState = Await;
			Await:
				if (memAck)
					nextState = (remaining == fifoLevelT'(1)) ? Play : Request;
			Play:
				if (newFrame)
					nextState = RefillWait;  // Pulses in other states are dropped
			RefillWait:
				if (!memWait)
				begin
					// Nothing to fetch when the buffer already sits at the target
					nextState = (level < fillTarget) ? Request : Play;
				end
			default:
				nextState = Halted;
		endcase
	end

	//////////////////////////////////////////////////
	// State, counters and read strobe
	//////////////////////////////////////////////////
	always_ff @(posedge SClk)
	begin
		if (reset)
		begin
			state     <= Halted;
			remaining <= '0;
			nextAddr  <= baseAddr;
			rdReg     <= 1'b0;
			playing   <= 1'b0;
		end
		else
		begin
			state <= nextState;
			case (state)
				Halted:
					if (!memWait)
						remaining <= fillTarget;  // Empty buffer, so a full prime
				Request:
					rdReg <= 1'b1;  // Strobe rises with the address below
				Await:
					if (memAck)
					begin
						rdReg     <= 1'b0;
						remaining <= remaining - fifoLevelT'(1);
						nextAddr  <= nextAddr + memAddrT'(1);
					end
				Play:
					playing <= 1'b1;  // Stays set, the timer never stops again
				RefillWait:
					// The count is frozen here, later pops only make room
					if (!memWait && level < fillTarget)
						remaining <= fillTarget - level;
				default:
					rdReg <= 1'b0;
			endcase
		end
	end

	// Address of the read being set up
	always_ff @(posedge SClk)
	begin
		if (state == Request)
			addrReg <= nextAddr;
	end

	assign memReq = '{rd: rdReg, addr: addrReg};
	assign push   = (state == Await) && memAck;  // memData is valid in the ack cycle
	assign busy   = (state == Request) || (state == Await);

	//////////////////////////////////////////////////
	// Memory handshake checks
	//////////////////////////////////////////////////
	// An acknowledge only answers the one read in flight
	ackWithReadA: assert property (@(posedge SClk) disable iff (reset)
		memAck |-> (state == Await) && memReq.rd);

endmodule

//--- verilog/frameTimer.sv
// I2S frame timer
// Counts bit slots, toggles the channel select and asks for each new sample
`include "audioSettings.svh"

module frameTimer import audioPkg::*;
(
	input  logic      SClk,
	input  logic      reset,
	input  logic      enable,
	output frameTickT tick
);

	localparam slotT lastSlot = slotT'(`AUDIO_SLOTS - 1);

	slotT slotCount;  // Bit slot of the current half frame
	logic lrReg;      // Low during the left half
	logic request;

	//////////////////////////////////////////////////
	// Slot counter and channel select
	//////////////////////////////////////////////////
	always_ff @(posedge SClk)
	begin
		if (reset || !enable)
		begin
			// Held at the start of a left half until playback runs
			slotCount <= '0;
			lrReg     <= 1'b0;
		end
		else
		begin
			if (slotCount == lastSlot)
			begin
				slotCount <= '0;
				lrReg     <= ~lrReg;  // Channel flips as the slot index wraps
			end
			else
			begin
				slotCount <= slotCount + slotT'(1);
			end
		end
	end

	// One request per half frame so the next word is ready for slot 0
	assign request = enable && (slotCount == lastSlot);

	assign tick = '{lrClk: lrReg, slot: slotCount, sampleRequest: request};

	//////////////////////////////////////////////////
	// Frame checks
	//////////////////////////////////////////////////
	// A request closes the half frame, the next cycle opens the other channel
	requestAtWrapA: assert property (@(posedge SClk) disable iff (reset)
		tick.sampleRequest |-> (tick.slot == lastSlot)
			##1 (tick.slot == '0) && (tick.lrClk != $past(tick.lrClk)));

endmodule

//--- verilog/audioFifo.sv
// Single-clock sample buffer
// Circular store with show-ahead head word, occupancy level and full and empty flags
`include "audioSettings.svh"

module audioFifo import audioPkg::*;
(
	input  logic      SClk,
	input  logic      reset,
	input  logic      push,
	input  sampleT    pushData,
	input  logic      pop,
	output sampleT    headData,
	output fifoLevelT level,
	output logic      empty,
	output logic      full
);

	localparam int ptrW = $clog2(`AUDIO_FIFO_DEPTH);

	sampleT          mem [`AUDIO_FIFO_DEPTH];
	logic [ptrW-1:0] wrPtr;  // Next free entry
	logic [ptrW-1:0] rdPtr;  // Oldest entry, shown on headData

	//////////////////////////////////////////////////
	// Storage
	//////////////////////////////////////////////////
	always_ff @(posedge SClk)
	begin
		if (push)
			mem[wrPtr] <= pushData;
	end

	// Head word is visible before the pop that removes it
	assign headData = mem[rdPtr];

	//////////////////////////////////////////////////
	// Pointers and occupancy
	//////////////////////////////////////////////////
	always_ff @(posedge SClk)
	begin
		if (reset)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			level <= '0;
		end
		else
		begin
			if (push)
				wrPtr <= wrPtr + 1'b1;  // Wraps by itself, depth is a power of two
			if (pop)
				rdPtr <= rdPtr + 1'b1;
			case ({push, pop})
				2'b10: level <= level + fifoLevelT'(1);
				2'b01: level <= level - fifoLevelT'(1);
				default: level <= level;  // Both or neither leave the count alone
			endcase
		end
	end

	assign empty = (level == '0);
	assign full  = (level == fifoLevelT'(`AUDIO_FIFO_DEPTH));

	//////////////////////////////////////////////////
	// Usage checks
	//////////////////////////////////////////////////
	// The fetch engine sizes every fill so it never runs past the depth
	noOverflowA: assert property (@(posedge SClk) disable iff (reset)
		push |-> !full);

	// The serializer falls back to a zero sample instead of popping
	noUnderflowA: assert property (@(posedge SClk) disable iff (reset)
		pop |-> !empty);

endmodule

//--- verilog/i2sSerializer.sv
// I2S serializer
// Loads one sample per half frame and shifts it out MSB first after a one slot delay
`include "audioSettings.svh"

module i2sSerializer import audioPkg::*;
(
	input  logic      SClk,
	input  logic      reset,
	input  frameTickT tick,
	input  sampleT    headData,
	input  logic      empty,
	output logic      pop,
	output logic      LRClk,
	output logic      Dout,
	output logic      underrun
);

	localparam slotT firstDataSlot = slotT'(1);
	localparam slotT lastDataSlot  = slotT'(`AUDIO_SAMPLE_W);

	sampleT shiftReg;  // Sample being sent, MSB goes out first
	logic   dataSlot;  // Slot carries a sample bit

	// Take the head word only when there is one
	assign pop = tick.sampleRequest && !empty;

	// Slot 0 is the I2S delay bit, zeros pad the slots after the sample
	assign dataSlot = (tick.slot >= firstDataSlot) && (tick.slot <= lastDataSlot);

	//////////////////////////////////////////////////
	// Shifter and output registers
	//////////////////////////////////////////////////
	always_ff @(posedge SClk)
	begin
		if (reset)
		begin
			shiftReg <= '0;  // First half frame plays silence
			LRClk    <= 1'b0;
			Dout     <= 1'b0;
			underrun <= 1'b0;
		end
		else
		begin
			// Both outputs trail the timer by one cycle and stay aligned
			LRClk <= tick.lrClk;
			Dout  <= dataSlot ? shiftReg[`AUDIO_SAMPLE_W-1] : 1'b0;

			if (tick.sampleRequest)
			begin
				if (empty)
				begin
					shiftReg <= '0;    // Silence instead of a stall
					underrun <= 1'b1;  // Sticky until the next reset
				end
				else
				begin
					shiftReg <= headData;
				end
			end
			else if (dataSlot)
			begin
				shiftReg <= {shiftReg[`AUDIO_SAMPLE_W-2:0], 1'b0};
			end
		end
	end

endmodule

//--- verilog/i2sPlayer.sv
// Streaming I2S audio player
// Fetches samples from external memory into a buffer and plays them as stereo I2S

module i2sPlayer import audioPkg::*;
(
	input  logic    SClk,
	input  logic    reset,
	input  logic    memWait,
	input  logic    memAck,
	input  sampleT  memData,
	input  logic    newFrame,
	output logic    memRd,
	output memAddrT memAddr,
	output logic    busy,
	output logic    LRClk,
	output logic    Dout,
	output logic    underrun
);

	memReqT    memReq;
	frameTickT tick;
	fifoLevelT level;
	sampleT    headData;
	logic      push;
	logic      pop;
	logic      empty;
	logic      playing;  // Starts the frame timer once the buffer is primed

	//////////////////////////////////////////////////
	// Memory side
	//////////////////////////////////////////////////
	sampleFetchFsm fetchInst (
		.SClk     (SClk),
		.reset    (reset),
		.memWait  (memWait),
		.memAck   (memAck),
		.newFrame (newFrame),
		.level    (level),
		.memReq   (memReq),
		.push     (push),
		.busy     (busy),
		.playing  (playing)
	);

	assign memRd   = memReq.rd;
	assign memAddr = memReq.addr;

	// Full is left open, every fill is sized against the level instead
	audioFifo fifoInst (
		.SClk     (SClk),
		.reset    (reset),
		.push     (push),
		.pushData (memData),  // Written in the ack cycle
		.pop      (pop),
		.headData (headData),
		.level    (level),
		.empty    (empty),
		.full     ()
	);

	//////////////////////////////////////////////////
	// Audio side
	//////////////////////////////////////////////////
	frameTimer timerInst (
		.SClk   (SClk),
		.reset  (reset),
		.enable (playing),
		.tick   (tick)
	);

	i2sSerializer serializerInst (
		.SClk     (SClk),
		.reset    (reset),
		.tick     (tick),
		.headData (headData),
		.empty    (empty),
		.pop      (pop),
		.LRClk    (LRClk),
		.Dout     (Dout),
		.underrun (underrun)
	);

endmodule

//--- verification/i2sPlayerTb.sv
// Testbench of the I2S audio player
// Memory model with random latency, I2S capture against a sample queue, five tests
`include "audioSettings.svh"

module i2sPlayerTb import audioPkg::*;
();

	localparam int      fillTarget = `AUDIO_FILL_TARGET;
	localparam int      sampleW    = `AUDIO_SAMPLE_W;
	localparam int      slots      = `AUDIO_SLOTS;
	localparam memAddrT baseAddr   = `AUDIO_BASE_ADDR;
	localparam logic [31:0] seed   = 32'h6964_945b;
	localparam int waitHigh = 0;    // memWait modes of the memory model
	localparam int waitLow = 1;
	localparam int waitRandom = 2;

	// Test lengths in cycles, the timeout adds a quarter on top
	localparam int resetCycles = 16;
	localparam int quietCycles = 20;
	localparam int primeCycles = fillTarget * 10 + 2 * slots;
	localparam int formatCycles = 8 * slots;
	localparam int orderHalves = 24;
	localparam int orderCycles = orderHalves * slots;
	localparam int underrunCycles = (fillTarget + 4 + 8) * slots;
	localparam int cycleLimit = (resetCycles + quietCycles + primeCycles + formatCycles
		+ orderCycles + underrunCycles) * 5 / 4;

	logic SClk, reset, memWait, memAck, newFrame;
	sampleT memData;
	logic memRd, busy, LRClk, Dout, underrun;
	memAddrT memAddr;

	sampleT sampleQueue [$];   // Expected samples in address order
	memAddrT expAddr;          // Next address the player has to read
	memAddrT reqAddr;          // Address of the read in flight
	logic pending;             // A read is waiting for its ack
	int ackDelay, waitLeft, waitMode, readCount;
	logic [31:0] memRng, frameRng;
	logic lastLr, inHalf, modelUnderrun;
	int slotIdx, halfCount, cycleCount, curTest, checkCount;
	sampleT expSample, gotBits;
	int testErrors [5];
	string curName;

	i2sPlayer i2sPlayer_inst (.*);

	initial
	begin
		SClk = 1'b0;
		forever #20 SClk = ~SClk;
	end

	// Xorshift32 step
	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// Memory word content, tied to the address
	function automatic sampleT sampleAt(input memAddrT addr);
		return addr[15:0] ^ 16'hA5C3;
	endfunction

	task automatic compareValue(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		checkCount++;
		if (expected !== actual)
		begin
			testErrors[curTest]++;
			$display("Fail %s, %s: expected %0h, actual %0h", curName, what, expected, actual);
		end
	endtask

	task automatic startTest(input int idx, input string name);
		curTest = idx;
		curName = name;
	endtask

	task automatic finishTest();
		$display("Test %0d %s finished with %0d mismatches", curTest + 1, curName,
			testErrors[curTest]);
	endtask

	// Returns on the rising edge after the given number of LRClk edges
	task automatic waitHalves(input int count);
		int target;
		target = halfCount + count;
		while (halfCount < target)
			@(posedge SClk);
	endtask

	//////////////////////////////////////////////////
	// Memory model
	//////////////////////////////////////////////////
	always @(posedge SClk)
	begin
		memAck <= 1'b0;
		if (reset)
		begin
			pending = 1'b0;
			expAddr = baseAddr;
			waitLeft = 0;
		end
		else if (pending)
		begin
			compareValue("read strobe held", 1, memRd);  // No ack yet, so no drop
			compareValue("read address held", reqAddr, memAddr);
		end
		else if (memRd && !memAck)
		begin
			// A new read, it must follow the previous one without gaps
			compareValue("read address", expAddr, memAddr);
			compareValue("busy during read", 1, busy);
			reqAddr = memAddr;
			readCount++;
			pending = 1'b1;
			memRng = xorshift32(memRng);
			ackDelay = 1 + memRng % 6;
		end
		if (!reset && pending)
		begin
			ackDelay--;
			if (ackDelay == 0)
			begin
				memAck  <= 1'b1;
				memData <= memAddr[15:0] ^ 16'hA5C3;
				sampleQueue.push_back(sampleAt(expAddr));
				expAddr = expAddr + 1'b1;
				// The buffer never holds more than the fill target
				compareValue("read within refill count", 1, sampleQueue.size() <= fillTarget);
				pending = 1'b0;
			end
		end
		// memWait stretches of 1 to 15 cycles with at least one low cycle between
		if (waitMode == waitHigh)
			memWait <= 1'b1;
		else if (waitMode == waitLow || waitLeft == 0 && memWait)
		begin
			memWait <= 1'b0;
			waitLeft = 0;
		end
		else if (waitLeft > 0)
		begin
			memWait <= 1'b1;
			waitLeft--;
		end
		else
		begin
			memRng = xorshift32(memRng);
			if (memRng[2:0] == 3'd0)
			begin
				memWait <= 1'b1;
				waitLeft = (memRng >> 8) % 15;
			end
		end
	end

	//////////////////////////////////////////////////
	// I2S capture, sampled on the falling edge
	//////////////////////////////////////////////////
	always @(negedge SClk)
	begin
		if (reset)
		begin
			lastLr = 1'b0;
			inHalf = 1'b0;
			slotIdx = 0;
		end
		else
		begin
			if (LRClk != lastLr)
			begin
				if (inHalf)
					compareValue("half frame length", slots, slotIdx + 1);
				inHalf = 1'b1;
				slotIdx = 0;
				halfCount++;
				gotBits = '0;
				compareValue("delay slot", 0, Dout);  // I2S one bit delay
				if (sampleQueue.size() > 0)
					expSample = sampleQueue.pop_front();
				else
				begin
					expSample = '0;         // Empty buffer plays silence
					modelUnderrun = 1'b1;
				end
				// The flag is raised by the request that opened this half frame
				compareValue("underrun flag", modelUnderrun, underrun);
			end
			else if (inHalf)
			begin
				slotIdx++;
				if (slotIdx <= sampleW)
					gotBits = {gotBits[sampleW-2:0], Dout};  // MSB arrives first
				else
					compareValue("padding slot", 0, Dout);
				if (slotIdx == slots - 1)
					compareValue("played sample", expSample, gotBits);
			end
			lastLr = LRClk;
		end
	end

	always @(posedge SClk)
	begin
		cycleCount++;
		if (cycleCount >= cycleLimit)
		begin
			$display("Timeout, the run did not finish within %0d cycles", cycleLimit);
			$display("test failed");
			$finish;
		end
	end

	//////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////
	initial
	begin
		int failedTests;
		int totalErrors;
		int readsBefore;
		reset = 1'b1;
		memWait = 1'b1;
		memAck = 1'b0;
		memData = '0;
		newFrame = 1'b0;
		waitMode = waitHigh;
		memRng = seed;
		frameRng = ~seed;       // Second stream from the same seed
		readCount = 0;
		halfCount = 0;
		cycleCount = 0;
		checkCount = 0;
		modelUnderrun = 1'b0;
		foreach (testErrors[i])
			testErrors[i] = 0;
		startTest(0, "resetQuiet");
		repeat (resetCycles) @(posedge SClk);
		reset <= 1'b0;
		repeat (quietCycles)
		begin
			@(negedge SClk);
			compareValue("quiet outputs", 0, {memRd, busy, LRClk, Dout, underrun});
		end
		finishTest();

		// Priming ends with the first channel switch
		startTest(1, "priming");
		@(posedge SClk);
		waitMode <= waitLow;
		waitHalves(1);
		compareValue("priming reads", fillTarget, readCount);
		finishTest();

		startTest(2, "frameFormat");
		waitHalves(8);
		finishTest();

		// One refill every two half frames, random frame pulse offset
		startTest(3, "sampleOrder");
		waitMode <= waitRandom;
		for (int i = 0; i < orderHalves; i++)
		begin
			waitHalves(1);
			if (i % 2 == 0)
			begin
				frameRng = xorshift32(frameRng);
				repeat (frameRng % 4) @(posedge SClk);
				newFrame <= 1'b1;
				@(posedge SClk);
				newFrame <= 1'b0;
			end
		end
		finishTest();

		// Drain the buffer, play silence for a while, then refill again
		startTest(4, "underrun");
		waitMode <= waitLow;
		while (!underrun)
			@(posedge SClk);
		waitHalves(3);
		readsBefore = readCount;
		newFrame <= 1'b1;
		@(posedge SClk);
		newFrame <= 1'b0;
		waitHalves(8);
		compareValue("refill after underrun", 1, readCount > readsBefore);
		finishTest();

		failedTests = 0;
		totalErrors = 0;
		foreach (testErrors[i])
		begin
			totalErrors += testErrors[i];
			if (testErrors[i] != 0)
				failedTests++;
		end
		$display("Summary: 5 tests, %0d failing, %0d checks, %0d mismatches", failedTests,
			checkCount, totalErrors);
		if (failedTests == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

//--- sources.f
+incdir+verilog
verilog/audioPkg.sv
verilog/sampleFetchFsm.sv
verilog/frameTimer.sv
verilog/audioFifo.sv
verilog/i2sSerializer.sv
verilog/i2sPlayer.sv
verification/i2sPlayerTb.sv
